// ==== design/memPkg.sv ====
package memPkg;

    // byte address space of the RAM
    localparam int addrWidth = 17;
    localparam int ramDepth = 1 << addrWidth;

    typedef logic [addrWidth-1:0] addrT;
    typedef logic [7:0] byteT;
    typedef logic [31:0] wordT;

    // access length codes on the data port
    typedef logic [1:0] lenT;

    localparam lenT lenByte = 2'd0;
    localparam lenT lenHalf = 2'd1;
    localparam lenT lenWord = 2'd2;

    // shared by both sequencers
    typedef enum logic [1:0] {
        idle,
        waitGrant,
        access,
        finish
    } seqStateT;

endpackage

// ==== design/fetchSequencer.sv ====
module fetchSequencer import memPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic stall,
    input  logic instEn,
    input  addrT instAddr,
    input  logic grant,
    input  byteT readByte,
    output logic req,
    output addrT byteAddr,
    output logic last,
    output logic instDone,
    output wordT instWord
);

    seqStateT state;
    logic [2:0] issueCnt;
    logic [1:0] capCnt;
    logic capPending;
    logic issue;

    // request stays up until all four bytes are out
    assign req = (state == waitGrant) || (state == access && issueCnt != 3'd4);
    assign issue = req && grant;
    assign byteAddr = instAddr + addrT'(issueCnt);
    assign last = issue && (issueCnt == 3'd3);
    assign instDone = (state == finish) && !stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            issueCnt <= '0;
            capCnt <= '0;
            capPending <= 1'b0;
        end else if (!stall) begin
            // RAM data for an issued byte shows up one cycle later
            capPending <= issue;
            if (issue) begin
                issueCnt <= issueCnt + 3'd1;
            end
            if (capPending) begin
                capCnt <= capCnt + 2'd1;
            end
            case (state)
                idle: begin
                    if (instEn) begin
                        state <= waitGrant;
                        issueCnt <= '0;
                        capCnt <= '0;
                    end
                end
                waitGrant: begin
                    if (issue) begin
                        state <= access;
                    end
                end
                access: begin
                    if (capPending && capCnt == 2'd3) begin
                        state <= finish;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // little-endian, first byte ends up in the low lane
    always_ff @(posedge clk) begin
        if (!stall && capPending) begin
            instWord <= {readByte, instWord[31:8]};
        end
    end

    doneSinglePulse: assert property (@(posedge clk) disable iff (rst)
        instDone |=> !instDone);

endmodule

// ==== design/dataSequencer.sv ====
module dataSequencer import memPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic stall,
    input  logic dataEn,
    input  logic dataStore,
    input  lenT  dataLen,
    input  addrT dataAddr,
    input  wordT dataWr,
    input  logic grant,
    input  byteT readByte,
    output logic req,
    output addrT byteAddr,
    output logic byteWe,
    output byteT byteWr,
    output logic last,
    output logic dataDone,
    output wordT dataRd
);

    seqStateT state;
    logic [2:0] issueCnt;
    logic [1:0] capCnt;
    logic [2:0] byteCount;
    logic capPending;
    logic issue;
    logic lastCapture;

    always_comb begin
        case (dataLen)
            lenByte: byteCount = 3'd1;
            lenHalf: byteCount = 3'd2;
            lenWord: byteCount = 3'd4;
            default: byteCount = 3'd4;
        endcase
    end

    assign req = (state == waitGrant) || (state == access && issueCnt != byteCount);
    assign issue = req && grant;
    assign byteAddr = dataAddr + addrT'(issueCnt);
    assign byteWe = issue && dataStore;
    assign byteWr = dataWr[{issueCnt[1:0], 3'b000} +: 8];
    assign last = issue && (issueCnt == byteCount - 3'd1);
    assign lastCapture = capPending && ({1'b0, capCnt} + 3'd1 == byteCount);
    assign dataDone = (state == finish) && !stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            issueCnt <= '0;
            capCnt <= '0;
            capPending <= 1'b0;
        end else if (!stall) begin
            // only loads wait for read data
            capPending <= issue && !dataStore;
            if (issue) begin
                issueCnt <= issueCnt + 3'd1;
            end
            if (capPending) begin
                capCnt <= capCnt + 2'd1;
            end
            case (state)
                idle: begin
                    if (dataEn) begin
                        state <= waitGrant;
                        issueCnt <= '0;
                        capCnt <= '0;
                    end
                end
                waitGrant: begin
                    // a one byte store is done on its first issue
                    if (last && dataStore) begin
                        state <= finish;
                    end else if (issue) begin
                        state <= access;
                    end
                end
                access: begin
                    if ((last && dataStore) || lastCapture) begin
                        state <= finish;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // upper lanes stay zero for short loads
    always_ff @(posedge clk) begin
        if (!stall) begin
            if (state == idle && dataEn) begin
                dataRd <= '0;
            end else if (capPending) begin
                dataRd[{capCnt, 3'b000} +: 8] <= readByte;
            end
        end
    end

    // a write byte never goes past the requested length
    writeOnlyGranted: assert property (@(posedge clk) disable iff (rst)
        byteWe |-> (grant && issueCnt < byteCount));

endmodule

// ==== design/ramPortArbiter.sv ====
module ramPortArbiter import memPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic stall,
    input  logic instReq,
    input  addrT instByteAddr,
    input  logic instLast,
    input  logic dataReq,
    input  addrT dataByteAddr,
    input  logic dataByteWe,
    input  byteT dataByteWr,
    input  logic dataLast,
    output logic instGrant,
    output logic dataGrant,
    output logic ramEn,
    output logic ramWe,
    output addrT ramAddr,
    output byteT ramWr
);

    logic locked;
    logic ownerData;
    logic holderLast;

    // free port goes to data first and a locked port stays with its owner
    always_comb begin
        if (locked) begin
            dataGrant = ownerData;
            instGrant = !ownerData;
        end else begin
            dataGrant = dataReq;
            instGrant = instReq && !dataReq;
        end
    end

    assign holderLast = dataGrant ? dataLast : (instGrant && instLast);

    always_ff @(posedge clk) begin
        if (rst) begin
            locked <= 1'b0;
            ownerData <= 1'b0;
        end else if (!stall) begin
            if (locked) begin
                if (holderLast) begin
                    locked <= 1'b0;
                end
            end else if ((dataGrant || instGrant) && !holderLast) begin
                locked <= 1'b1;
                ownerData <= dataGrant;
            end
        end
    end

    assign ramEn = !stall;
    assign ramWe = dataGrant && dataByteWe;
    assign ramAddr = dataGrant ? dataByteAddr : instByteAddr;
    assign ramWr = dataByteWr;

    // a locked grant belongs to a port that still has bytes to issue
    grantHeldByRequester: assert property (@(posedge clk) disable iff (rst)
        locked |-> (ownerData ? dataReq : instReq));

endmodule

// ==== design/byteRam.sv ====
module byteRam import memPkg::*; (
    input  logic clk,
    input  logic en,
    input  logic we,
    input  addrT addr,
    input  byteT wr,
    output byteT rd
);

    byteT mem [ramDepth];

    initial begin
        for (int i = 0; i < ramDepth; i++) begin
            mem[i] = '0;
        end
    end

    // read returns the old byte on a write to the same address
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wr;
            end
            rd <= mem[addr];
        end
    end

endmodule

// ==== design/memCtrl.sv ====
module memCtrl import memPkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic ioBufferFull,

    input  logic instEn,
    input  addrT instAddr,
    output logic instDone,
    output wordT instWord,

    input  logic dataEn,
    input  logic dataStore,
    input  lenT  dataLen,
    input  addrT dataAddr,
    input  wordT dataWr,
    output logic dataDone,
    output wordT dataRd
);

    logic instReq;
    logic instGrant;
    logic instLast;
    addrT instByteAddr;

    logic dataReq;
    logic dataGrant;
    logic dataLast;
    logic dataByteWe;
    addrT dataByteAddr;
    byteT dataByteWr;

    logic ramEn;
    logic ramWe;
    addrT ramAddr;
    byteT ramWr;
    byteT readByte;

    fetchSequencer fetchSeq (
        .clk(clk),
        .rst(rst),
        .stall(ioBufferFull),
        .instEn(instEn),
        .instAddr(instAddr),
        .grant(instGrant),
        .readByte(readByte),
        .req(instReq),
        .byteAddr(instByteAddr),
        .last(instLast),
        .instDone(instDone),
        .instWord(instWord)
    );

    dataSequencer dataSeq (
        .clk(clk),
        .rst(rst),
        .stall(ioBufferFull),
        .dataEn(dataEn),
        .dataStore(dataStore),
        .dataLen(dataLen),
        .dataAddr(dataAddr),
        .dataWr(dataWr),
        .grant(dataGrant),
        .readByte(readByte),
        .req(dataReq),
        .byteAddr(dataByteAddr),
        .byteWe(dataByteWe),
        .byteWr(dataByteWr),
        .last(dataLast),
        .dataDone(dataDone),
        .dataRd(dataRd)
    );

    ramPortArbiter arbiter (
        .clk(clk),
        .rst(rst),
        .stall(ioBufferFull),
        .instReq(instReq),
        .instByteAddr(instByteAddr),
        .instLast(instLast),
        .dataReq(dataReq),
        .dataByteAddr(dataByteAddr),
        .dataByteWe(dataByteWe),
        .dataByteWr(dataByteWr),
        .dataLast(dataLast),
        .instGrant(instGrant),
        .dataGrant(dataGrant),
        .ramEn(ramEn),
        .ramWe(ramWe),
        .ramAddr(ramAddr),
        .ramWr(ramWr)
    );

    byteRam ram (
        .clk(clk),
        .en(ramEn),
        .we(ramWe),
        .addr(ramAddr),
        .wr(ramWr),
        .rd(readByte)
    );

endmodule

// ==== tb/memCtrlTb.sv ====
module memCtrlTb import memPkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int numRandom = 200;
    localparam int numDirected = 40;
    localparam int worstLatency = 100;
    localparam int cycleLimit = (2 * numRandom + numDirected) * worstLatency + 500;
    localparam addrT randBase = 17'h1ffe0;

    logic clk;
    logic rst;
    logic ioBufferFull;
    logic instEn;
    addrT instAddr;
    logic instDone;
    wordT instWord;
    logic dataEn;
    logic dataStore;
    lenT  dataLen;
    addrT dataAddr;
    wordT dataWr;
    logic dataDone;
    wordT dataRd;

    logic [31:0] lfsr = 32'hdc83_5309;
    byteT shadow [ramDepth];
    lenT lens [3] = '{lenByte, lenHalf, lenWord};
    string testName = "reset";
    wordT expInst;
    wordT expData;
    logic dataIsLoad = 1'b0;
    logic instBusy = 1'b0;
    logic dataBusy = 1'b0;
    logic stallOn = 1'b0;
    int stallLeft = 0;
    int instDoneCycle = 0;
    int dataDoneCycle = 0;
    int cycles = 0;
    int checks = 0;
    int errors = 0;

    memCtrl uut (
        .clk(clk),
        .rst(rst),
        .ioBufferFull(ioBufferFull),
        .instEn(instEn),
        .instAddr(instAddr),
        .instDone(instDone),
        .instWord(instWord),
        .dataEn(dataEn),
        .dataStore(dataStore),
        .dataLen(dataLen),
        .dataAddr(dataAddr),
        .dataWr(dataWr),
        .dataDone(dataDone),
        .dataRd(dataRd)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic takeBits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            val = {val[30:0], lfsr[0]};
        end
    endtask

    function automatic int lenBytes(input lenT len);
        case (len)
            lenByte: return 1;
            lenHalf: return 2;
            default: return 4;
        endcase
    endfunction

    // little-endian, upper bytes zero for short lengths
    function automatic wordT expectedLoad(input addrT addr, input lenT len);
        wordT w;
        w = '0;
        for (int i = 0; i < lenBytes(len); i++) begin
            w[8*i +: 8] = shadow[addr + addrT'(i)];
        end
        return w;
    endfunction

    function automatic void updateShadow(input addrT addr, input lenT len, input wordT wr);
        for (int i = 0; i < lenBytes(len); i++) begin
            shadow[addr + addrT'(i)] = wr[8*i +: 8];
        end
    endfunction

    task automatic checkValue(input string name, input wordT expected, input wordT actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic launchData(input logic store, input lenT len, input addrT addr,
                              input wordT wr);
        dataStore = store;
        dataLen = len;
        dataAddr = addr;
        dataWr = wr;
        dataEn = 1'b1;
        dataIsLoad = !store;
        if (store) begin
            updateShadow(addr, len, wr);
        end else begin
            expData = expectedLoad(addr, len);
        end
        dataBusy = 1'b1;
    endtask

    task automatic launchFetch(input addrT addr);
        instAddr = addr;
        instEn = 1'b1;
        expInst = expectedLoad(addr, lenWord);
        instBusy = 1'b1;
    endtask

    // random stretches of back-pressure
    task automatic driveStall();
        logic [31:0] r;
        if (!stallOn) begin
            ioBufferFull = 1'b0;
        end else if (stallLeft > 0) begin
            stallLeft--;
            ioBufferFull = 1'b1;
        end else begin
            takeBits(2, r);
            if (r == 0) begin
                takeBits(3, r);
                stallLeft = int'(r);
                ioBufferFull = 1'b1;
            end else begin
                ioBufferFull = 1'b0;
            end
        end
    endtask

    // each enable drops right after its own done pulse
    task automatic waitDone();
        while (instBusy || dataBusy) begin
            @(negedge clk);
            if (!instBusy) begin
                instEn = 1'b0;
            end
            if (!dataBusy) begin
                dataEn = 1'b0;
            end
            driveStall();
        end
        ioBufferFull = 1'b0;
        stallLeft = 0;
    endtask

    task automatic doStore(input lenT len, input addrT addr, input wordT wr);
        launchData(1'b1, len, addr, wr);
        waitDone();
    endtask

    task automatic doLoad(input lenT len, input addrT addr);
        launchData(1'b0, len, addr, '0);
        waitDone();
    endtask

    task automatic doFetch(input addrT addr);
        launchFetch(addr);
        waitDone();
    endtask

    task automatic doPair(input logic store, input lenT len, input addrT addr,
                          input wordT wr, input addrT fetchAddr);
        launchData(store, len, addr, wr);
        launchFetch(fetchAddr);
        waitDone();
        if (dataDoneCycle > instDoneCycle) begin
            errors++;
            $display("%s: data port finished after the instruction port", testName);
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (ioBufferFull && (instDone || dataDone)) begin
                errors++;
                $display("%s: done pulse while ioBufferFull was high", testName);
            end
            if (instDone) begin
                if (!instBusy) begin
                    errors++;
                    $display("%s: instDone without an open fetch", testName);
                end
                checkValue({testName, " fetch"}, expInst, instWord);
                instDoneCycle = cycles;
                instBusy = 1'b0;
            end
            if (dataDone) begin
                if (!dataBusy) begin
                    errors++;
                    $display("%s: dataDone without an open data request", testName);
                end
                if (dataIsLoad) begin
                    checkValue({testName, " load"}, expData, dataRd);
                end
                dataDoneCycle = cycles;
                dataBusy = 1'b0;
            end
        end
    end

    initial begin
        wait (cycles >= cycleLimit);
        $display("timeout: the run did not finish within %0d cycles", cycleLimit);
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [31:0] wr;
        lenT len;
        addrT a;
        rst = 1'b1;
        ioBufferFull = 1'b0;
        instEn = 1'b0;
        instAddr = '0;
        dataEn = 1'b0;
        dataStore = 1'b0;
        dataLen = lenByte;
        dataAddr = '0;
        dataWr = '0;
        for (int i = 0; i < ramDepth; i++) begin
            shadow[i] = '0;
        end
        repeat (2) @(negedge clk);
        rst = 1'b0;

        testName = "storeLoad";
        for (int k = 0; k < 3; k++) begin
            doStore(lens[k], addrT'(17'h00100 + 16 * k), 32'ha1b2_c3d4 + k);
            doLoad(lens[k], addrT'(17'h00100 + 16 * k));
            // crosses the top of the address space
            doStore(lens[k], 17'h1fffe, 32'h5566_7788 ^ k);
            doLoad(lens[k], 17'h1fffe);
        end

        testName = "fetch";
        doStore(lenWord, 17'h00400, 32'h0011_2233);
        doFetch(17'h00400);
        for (int k = 0; k < 4; k++) begin
            doStore(lenByte, addrT'(17'h00500 + k), 32'h0000_0090 + k);
        end
        doFetch(17'h00500);

        testName = "contention";
        doPair(1'b1, lenWord, 17'h00600, 32'hcafe_f00d, 17'h00600);
        doPair(1'b0, lenWord, 17'h00100, '0, 17'h00400);
        doPair(1'b1, lenHalf, 17'h00700, 32'h0000_beef, 17'h00100);

        testName = "stall";
        stallOn = 1'b1;
        for (int k = 0; k < 3; k++) begin
            doStore(lens[k], addrT'(17'h00800 + 8 * k), 32'h1357_9bdf + k);
            doLoad(lens[k], addrT'(17'h00800 + 8 * k));
        end
        doFetch(17'h00800);
        doPair(1'b0, lenHalf, 17'h00808, '0, 17'h00600);

        testName = "randomMix";
        for (int i = 0; i < numRandom; i++) begin
            stallOn = (i >= numRandom / 2);
            takeBits(2, r);
            len = (r[1:0] == 2'd3) ? lenWord : lenT'(r[1:0]);
            takeBits(6, wr);
            a = randBase + addrT'(wr);
            takeBits(32, wr);
            takeBits(2, r);
            case (r[1:0])
                2'd0: doFetch(a);
                2'd1: doLoad(len, a);
                2'd2: doStore(len, a, wr);
                default: begin
                    takeBits(1, r);
                    doPair(r[0], len, a, wr, a + addrT'(2));
                end
            endcase
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
design/memPkg.sv
design/fetchSequencer.sv
design/dataSequencer.sv
design/ramPortArbiter.sv
design/byteRam.sv
design/memCtrl.sv
tb/memCtrlTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= memCtrlTb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(BUILD_DIR)
